//--- sha_axi_pkg.sv
package sha_axi_pkg;

	////////////////////////////////////////
	// Bus geometry
	localparam int DATA_WIDTH = 32;
	localparam int ADDR_WIDTH = 8;
	localparam int ADDR_LSB   = 2;

	////////////////////////////////////////
	// Engine geometry
	localparam int MSG_WORDS    = 32;
	localparam int LEN_WORDS    = 4;
	localparam int RESULT_WORDS = 12;

	// Word slots, one per 32-bit register
	// Indices 51 and up are not mapped
	typedef enum logic [ADDR_WIDTH-ADDR_LSB-1:0] {
		REG_CTRL     = 0,
		REG_LEN0     = 1,
		REG_MSG0     = 5,
		REG_MSG_LAST = 36,
		REG_CYCLES   = 37,
		REG_CLEAR    = 38,
		REG_RESULT0  = 39
	} reg_idx_e;

	// Cycle counter run state
	typedef enum logic {
		RUN_IDLE     = 1'b0,
		RUN_COUNTING = 1'b1
	} run_state_e;

endpackage

//--- axil_slave_port.sv
module axil_slave_port import sha_axi_pkg::*; (
	input  logic                    S_AXI_ACLK,
	input  logic                    S_AXI_ARESETN,

	// Write address
	input  logic [ADDR_WIDTH-1:0]   S_AXI_AWADDR,
	input  logic                    S_AXI_AWVALID,
	output logic                    S_AXI_AWREADY,

	// Write data
	input  logic [DATA_WIDTH-1:0]   S_AXI_WDATA,
	input  logic [DATA_WIDTH/8-1:0] S_AXI_WSTRB,
	input  logic                    S_AXI_WVALID,
	output logic                    S_AXI_WREADY,

	// Write response
	output logic [1:0]              S_AXI_BRESP,
	output logic                    S_AXI_BVALID,
	input  logic                    S_AXI_BREADY,

	// Read address
	input  logic [ADDR_WIDTH-1:0]   S_AXI_ARADDR,
	input  logic                    S_AXI_ARVALID,
	output logic                    S_AXI_ARREADY,

	// Read data
	output logic [DATA_WIDTH-1:0]   S_AXI_RDATA,
	output logic [1:0]              S_AXI_RRESP,
	output logic                    S_AXI_RVALID,
	input  logic                    S_AXI_RREADY,

	// Register block side
	output logic                    wr_en,
	output reg_idx_e                wr_idx,
	output logic [DATA_WIDTH-1:0]   wr_data,
	output logic [DATA_WIDTH/8-1:0] wr_strb,
	output reg_idx_e                rd_idx,
	input  logic [DATA_WIDTH-1:0]   rd_data
);

	localparam logic [1:0] RESP_OKAY = 2'b00;

	logic                  wr_ready;
	logic                  wr_accept;
	logic                  b_valid;
	logic                  ar_ready;
	logic                  rd_accept;
	logic                  r_valid;
	logic [DATA_WIDTH-1:0] r_data;

	// AWREADY and WREADY share one register
	assign S_AXI_AWREADY = wr_ready;
	assign S_AXI_WREADY  = wr_ready;
	assign S_AXI_BVALID  = b_valid;
	assign S_AXI_BRESP   = RESP_OKAY;

	assign S_AXI_ARREADY = ar_ready;
	assign S_AXI_RVALID  = r_valid;
	assign S_AXI_RDATA   = r_data;
	assign S_AXI_RRESP   = RESP_OKAY;

	////////////////////////////////////////
	// Write channel

	// No new write while a response is still pending
	assign wr_accept = !wr_ready && !b_valid && S_AXI_AWVALID && S_AXI_WVALID;

	assign wr_en   = wr_ready;
	assign wr_data = S_AXI_WDATA;
	assign wr_strb = S_AXI_WSTRB;

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			wr_ready <= 1'b0;
		end else begin
			wr_ready <= wr_accept;
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (wr_accept) begin
			wr_idx <= reg_idx_e'(S_AXI_AWADDR[ADDR_WIDTH-1:ADDR_LSB]);
		end
	end

	// Response held until the master takes it
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			b_valid <= 1'b0;
		end else if (wr_en) begin
			b_valid <= 1'b1;
		end else if (S_AXI_BREADY) begin
			b_valid <= 1'b0;
		end
	end

	////////////////////////////////////////
	// Read channel

	assign rd_accept = !ar_ready && !r_valid && S_AXI_ARVALID;

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			ar_ready <= 1'b0;
		end else begin
			ar_ready <= rd_accept;
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (rd_accept) begin
			rd_idx <= reg_idx_e'(S_AXI_ARADDR[ADDR_WIDTH-1:ADDR_LSB]);
		end
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			r_valid <= 1'b0;
		end else if (ar_ready) begin
			r_valid <= 1'b1;
		end else if (S_AXI_RREADY) begin
			r_valid <= 1'b0;
		end
	end

	// Snapshot of the register taken in the ARREADY cycle
	always_ff @(posedge S_AXI_ACLK) begin
		if (ar_ready) begin
			r_data <= rd_data;
		end
	end

endmodule

//--- sha_reg_block.sv
module sha_reg_block import sha_axi_pkg::*; #(
	parameter int MSG_WORDS    = sha_axi_pkg::MSG_WORDS,
	parameter int RESULT_WORDS = sha_axi_pkg::RESULT_WORDS
) (
	input  logic                             S_AXI_ACLK,
	input  logic                             S_AXI_ARESETN,

	// Write and read ports from the bus side
	input  logic                             wr_en,
	input  reg_idx_e                         wr_idx,
	input  logic [DATA_WIDTH-1:0]            wr_data,
	input  logic [DATA_WIDTH/8-1:0]          wr_strb,
	input  reg_idx_e                         rd_idx,
	output logic [DATA_WIDTH-1:0]            rd_data,

	// Run control
	input  logic                             soft_clear,
	input  logic [DATA_WIDTH-1:0]            cycles,
	output logic                             start_req,
	output logic                             clear_req,

	// Engine
	input  logic                             hash_ready,
	input  logic                             hash_done,
	input  logic [RESULT_WORDS*DATA_WIDTH-1:0] hash_code,
	output logic [MSG_WORDS*DATA_WIDTH-1:0]  hash_msg,
	output logic [LEN_WORDS*DATA_WIDTH-1:0]  hash_len,
	output logic                             hash_mode
);

	logic                  mode;
	logic [DATA_WIDTH-1:0] len_q [LEN_WORDS];
	logic [DATA_WIDTH-1:0] msg_q [MSG_WORDS];

	// Lanes with a low strobe keep the old byte
	function automatic logic [DATA_WIDTH-1:0] merge_bytes(
		input logic [DATA_WIDTH-1:0]   old_word,
		input logic [DATA_WIDTH-1:0]   new_word,
		input logic [DATA_WIDTH/8-1:0] strb
	);
		logic [DATA_WIDTH-1:0] merged;
		merged = old_word;
		for (int b = 0; b < DATA_WIDTH / 8; b++) begin
			if (strb[b]) begin
				merged[b*8 +: 8] = new_word[b*8 +: 8];
			end
		end
		return merged;
	endfunction

	////////////////////////////////////////
	// Writable registers

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN || soft_clear) begin
			mode <= 1'b0;
			for (int i = 0; i < LEN_WORDS; i++) begin
				len_q[i] <= '0;
			end
			for (int i = 0; i < MSG_WORDS; i++) begin
				msg_q[i] <= '0;
			end
		end else if (wr_en) begin
			if (wr_idx == REG_CTRL && wr_strb[0]) begin
				mode <= wr_data[0];
			end
			for (int i = 0; i < LEN_WORDS; i++) begin
				if (int'(wr_idx) == int'(REG_LEN0) + i) begin
					len_q[i] <= merge_bytes(len_q[i], wr_data, wr_strb);
				end
			end
			for (int i = 0; i < MSG_WORDS; i++) begin
				if (int'(wr_idx) == int'(REG_MSG0) + i) begin
					msg_q[i] <= merge_bytes(msg_q[i], wr_data, wr_strb);
				end
			end
		end
	end

	// Command slots, one pulse per write
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			start_req <= 1'b0;
			clear_req <= 1'b0;
		end else begin
			start_req <= wr_en && (wr_idx == REG_MSG_LAST);
			clear_req <= wr_en && (wr_idx == REG_CLEAR);
		end
	end

	////////////////////////////////////////
	// Engine side, first word on top
	always_comb begin
		for (int i = 0; i < MSG_WORDS; i++) begin
			hash_msg[(MSG_WORDS-1-i)*DATA_WIDTH +: DATA_WIDTH] = msg_q[i];
		end
		for (int i = 0; i < LEN_WORDS; i++) begin
			hash_len[(LEN_WORDS-1-i)*DATA_WIDTH +: DATA_WIDTH] = len_q[i];
		end
	end

	assign hash_mode = mode;

	////////////////////////////////////////
	// Read multiplexer
	always_comb begin
		rd_data = '0;
		case (rd_idx)
			REG_CTRL: begin
				rd_data[DATA_WIDTH-1] = hash_ready;
				rd_data[DATA_WIDTH-2] = hash_done;
				rd_data[0]            = mode;
			end
			REG_CYCLES: rd_data = cycles;
			REG_CLEAR:  rd_data = '1;
			default: ;
		endcase
		for (int i = 0; i < LEN_WORDS; i++) begin
			if (int'(rd_idx) == int'(REG_LEN0) + i) begin
				rd_data = len_q[i];
			end
		end
		for (int i = 0; i < MSG_WORDS; i++) begin
			if (int'(rd_idx) == int'(REG_MSG0) + i) begin
				rd_data = msg_q[i];
			end
		end
		// result word 0 is the top slice of hash_code
		for (int k = 0; k < RESULT_WORDS; k++) begin
			if (int'(rd_idx) == int'(REG_RESULT0) + k) begin
				rd_data = hash_code[(RESULT_WORDS-1-k)*DATA_WIDTH +: DATA_WIDTH];
			end
		end
	end

endmodule

//--- sha_run_ctrl.sv
module sha_run_ctrl import sha_axi_pkg::*; (
	input  logic                  S_AXI_ACLK,
	input  logic                  S_AXI_ARESETN,
	input  logic                  start_req,
	input  logic                  clear_req,
	input  logic                  hash_ready,
	input  logic                  hash_done,
	output logic                  hash_run,
	output logic                  hash_rst_n,
	output logic                  soft_clear,
	output logic [DATA_WIDTH-1:0] cycles
);

	run_state_e state;

	// Engine sees the start in the same cycle as the request
	assign hash_run   = start_req;
	assign hash_rst_n = S_AXI_ARESETN && !soft_clear;

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			soft_clear <= 1'b0;
		end else begin
			soft_clear <= clear_req;
		end
	end

	////////////////////////////////////////
	// Run state
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN || soft_clear) begin
			state <= RUN_IDLE;
		end else begin
			case (state)
				RUN_IDLE: begin
					if (start_req) begin
						state <= RUN_COUNTING;
					end
				end
				RUN_COUNTING: begin
					// A new start keeps it running
					if (!start_req && (hash_ready || hash_done)) begin
						state <= RUN_IDLE;
					end
				end
				default: state <= RUN_IDLE;
			endcase
		end
	end

	// Restarts from zero on every start
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN || soft_clear) begin
			cycles <= '0;
		end else if (start_req) begin
			cycles <= '0;
		end else if (state == RUN_COUNTING) begin
			cycles <= cycles + 1'b1;
		end
	end

endmodule

//--- sha_axi.sv
module sha_axi import sha_axi_pkg::*; #(
	parameter int MSG_WORDS    = sha_axi_pkg::MSG_WORDS,
	parameter int RESULT_WORDS = sha_axi_pkg::RESULT_WORDS
) (
	input  logic                               S_AXI_ACLK,
	input  logic                               S_AXI_ARESETN,

	////////////////////////////////////////
	// AXI4-Lite slave
	input  logic [ADDR_WIDTH-1:0]              S_AXI_AWADDR,
	input  logic                               S_AXI_AWVALID,
	output logic                               S_AXI_AWREADY,
	input  logic [DATA_WIDTH-1:0]              S_AXI_WDATA,
	input  logic [DATA_WIDTH/8-1:0]            S_AXI_WSTRB,
	input  logic                               S_AXI_WVALID,
	output logic                               S_AXI_WREADY,
	output logic [1:0]                         S_AXI_BRESP,
	output logic                               S_AXI_BVALID,
	input  logic                               S_AXI_BREADY,
	input  logic [ADDR_WIDTH-1:0]              S_AXI_ARADDR,
	input  logic                               S_AXI_ARVALID,
	output logic                               S_AXI_ARREADY,
	output logic [DATA_WIDTH-1:0]              S_AXI_RDATA,
	output logic [1:0]                         S_AXI_RRESP,
	output logic                               S_AXI_RVALID,
	input  logic                               S_AXI_RREADY,

	////////////////////////////////////////
	// Hash engine
	output logic [MSG_WORDS*DATA_WIDTH-1:0]    hash_msg,
	output logic [LEN_WORDS*DATA_WIDTH-1:0]    hash_len,
	output logic                               hash_mode,
	output logic                               hash_run,
	output logic                               hash_rst_n,
	input  logic                               hash_ready,
	input  logic                               hash_done,
	input  logic [RESULT_WORDS*DATA_WIDTH-1:0] hash_code
);

	logic                  wr_en;
	reg_idx_e              wr_idx;
	logic [DATA_WIDTH-1:0] wr_data;
	logic [DATA_WIDTH/8-1:0] wr_strb;
	reg_idx_e              rd_idx;
	logic [DATA_WIDTH-1:0] rd_data;
	logic                  start_req;
	logic                  clear_req;
	logic                  soft_clear;
	logic [DATA_WIDTH-1:0] cycles;

	axil_slave_port port_i (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.S_AXI_AWADDR  (S_AXI_AWADDR),
		.S_AXI_AWVALID (S_AXI_AWVALID),
		.S_AXI_AWREADY (S_AXI_AWREADY),
		.S_AXI_WDATA   (S_AXI_WDATA),
		.S_AXI_WSTRB   (S_AXI_WSTRB),
		.S_AXI_WVALID  (S_AXI_WVALID),
		.S_AXI_WREADY  (S_AXI_WREADY),
		.S_AXI_BRESP   (S_AXI_BRESP),
		.S_AXI_BVALID  (S_AXI_BVALID),
		.S_AXI_BREADY  (S_AXI_BREADY),
		.S_AXI_ARADDR  (S_AXI_ARADDR),
		.S_AXI_ARVALID (S_AXI_ARVALID),
		.S_AXI_ARREADY (S_AXI_ARREADY),
		.S_AXI_RDATA   (S_AXI_RDATA),
		.S_AXI_RRESP   (S_AXI_RRESP),
		.S_AXI_RVALID  (S_AXI_RVALID),
		.S_AXI_RREADY  (S_AXI_RREADY),
		.wr_en         (wr_en),
		.wr_idx        (wr_idx),
		.wr_data       (wr_data),
		.wr_strb       (wr_strb),
		.rd_idx        (rd_idx),
		.rd_data       (rd_data)
	);

	sha_reg_block #(
		.MSG_WORDS    (MSG_WORDS),
		.RESULT_WORDS (RESULT_WORDS)
	) regs_i (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.wr_en         (wr_en),
		.wr_idx        (wr_idx),
		.wr_data       (wr_data),
		.wr_strb       (wr_strb),
		.rd_idx        (rd_idx),
		.rd_data       (rd_data),
		.soft_clear    (soft_clear),
		.cycles        (cycles),
		.start_req     (start_req),
		.clear_req     (clear_req),
		.hash_ready    (hash_ready),
		.hash_done     (hash_done),
		.hash_code     (hash_code),
		.hash_msg      (hash_msg),
		.hash_len      (hash_len),
		.hash_mode     (hash_mode)
	);

	sha_run_ctrl run_i (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.start_req     (start_req),
		.clear_req     (clear_req),
		.hash_ready    (hash_ready),
		.hash_done     (hash_done),
		.hash_run      (hash_run),
		.hash_rst_n    (hash_rst_n),
		.soft_clear    (soft_clear),
		.cycles        (cycles)
	);

endmodule

//--- tb_clock.sv
module tb_clock (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Reset held over the first two rising edges
	initial begin
		rst_n = 1'b0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
	end

endmodule

//--- sha_axi_properties.sv
module sha_axi_properties import sha_axi_pkg::*; (
	input logic                  S_AXI_ACLK,
	input logic                  S_AXI_ARESETN,
	input logic                  S_AXI_AWVALID,
	input logic                  S_AXI_WVALID,
	input logic                  S_AXI_AWREADY,
	input logic                  S_AXI_WREADY,
	input logic                  S_AXI_BVALID,
	input logic                  S_AXI_BREADY,
	input logic                  S_AXI_RVALID,
	input logic                  S_AXI_RREADY,
	input logic                  hash_run,
	input logic                  hash_ready,
	input logic                  hash_done,
	input logic                  start_req,
	input logic                  soft_clear,
	input logic [DATA_WIDTH-1:0] cycles
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;
	run_state_e run_state;

	// Run state as seen from the start and done handshake
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN || soft_clear) begin
			run_state <= RUN_IDLE;
		end else if (start_req) begin
			run_state <= RUN_COUNTING;
		end else if (hash_ready || hash_done) begin
			run_state <= RUN_IDLE;
		end
	end

	////////////////////////////////////////
	// Bus handshakes

	// Both ready lines rise together, on the edge after both valids
	aw_w_together: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		$rose(S_AXI_AWREADY || S_AXI_WREADY) |->
			S_AXI_AWREADY && S_AXI_WREADY && $past(S_AXI_AWVALID && S_AXI_WVALID))
	else begin
		$error("Write ready raised without both valids or on one channel only");
		fail_count++;
	end

	no_write_while_bvalid: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_BVALID |-> !S_AXI_AWREADY)
	else begin
		$error("Write accepted while a response is pending");
		fail_count++;
	end

	bvalid_held: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID)
	else begin
		$error("BVALID dropped before BREADY");
		fail_count++;
	end

	rvalid_held: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID)
	else begin
		$error("RVALID dropped before RREADY");
		fail_count++;
	end

	////////////////////////////////////////
	// Run control
	run_one_cycle: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		hash_run |=> !hash_run)
	else begin
		$error("hash_run lasted more than one cycle");
		fail_count++;
	end

	cycles_stable_idle: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		run_state == RUN_IDLE && !start_req && !soft_clear |=> $stable(cycles))
	else begin
		$error("Cycle counter moved while idle");
		fail_count++;
	end

endmodule

bind sha_axi sha_axi_properties props_i (
	.S_AXI_ACLK    (S_AXI_ACLK),
	.S_AXI_ARESETN (S_AXI_ARESETN),
	.S_AXI_AWVALID (S_AXI_AWVALID),
	.S_AXI_WVALID  (S_AXI_WVALID),
	.S_AXI_AWREADY (S_AXI_AWREADY),
	.S_AXI_WREADY  (S_AXI_WREADY),
	.S_AXI_BVALID  (S_AXI_BVALID),
	.S_AXI_BREADY  (S_AXI_BREADY),
	.S_AXI_RVALID  (S_AXI_RVALID),
	.S_AXI_RREADY  (S_AXI_RREADY),
	.hash_run      (hash_run),
	.hash_ready    (hash_ready),
	.hash_done     (hash_done),
	.start_req     (start_req),
	.soft_clear    (soft_clear),
	.cycles        (cycles)
);

//--- tb_sha_axi.sv
module tb_sha_axi import sha_axi_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int WAIT_LIMIT = 64;
	localparam int POLL_LIMIT = 50;
	localparam int SLOTS      = 1 << (ADDR_WIDTH - ADDR_LSB);
	localparam int UNMAPPED   = 60;

	typedef enum {FLAG_RESET_DONE, FLAG_AWREADY, FLAG_BVALID, FLAG_ARREADY, FLAG_RVALID} flag_e;

	logic                               S_AXI_ACLK;
	logic                               S_AXI_ARESETN;
	logic [ADDR_WIDTH-1:0]              S_AXI_AWADDR = '0;
	logic                               S_AXI_AWVALID = 1'b0;
	logic                               S_AXI_AWREADY;
	logic [DATA_WIDTH-1:0]              S_AXI_WDATA = '0;
	logic [DATA_WIDTH/8-1:0]            S_AXI_WSTRB = '0;
	logic                               S_AXI_WVALID = 1'b0;
	logic                               S_AXI_WREADY;
	logic [1:0]                         S_AXI_BRESP;
	logic                               S_AXI_BVALID;
	logic                               S_AXI_BREADY = 1'b1;
	logic [ADDR_WIDTH-1:0]              S_AXI_ARADDR = '0;
	logic                               S_AXI_ARVALID = 1'b0;
	logic                               S_AXI_ARREADY;
	logic [DATA_WIDTH-1:0]              S_AXI_RDATA;
	logic [1:0]                         S_AXI_RRESP;
	logic                               S_AXI_RVALID;
	logic                               S_AXI_RREADY = 1'b1;
	logic [MSG_WORDS*DATA_WIDTH-1:0]    hash_msg;
	logic [LEN_WORDS*DATA_WIDTH-1:0]    hash_len;
	logic                               hash_mode;
	logic                               hash_run;
	logic                               hash_rst_n;
	logic                               hash_ready = 1'b0;
	logic                               hash_done = 1'b0;
	logic [RESULT_WORDS*DATA_WIDTH-1:0] hash_code = '0;

	int seed = 22;
	int errors = 0;
	int done_delay = 0;
	int countdown = 0;
	int rst_low_cycles = 0;
	logic aborted = 1'b0;
	logic [DATA_WIDTH-1:0] slot_exp [SLOTS];

	tb_clock clock_i (
		.clk   (S_AXI_ACLK),
		.rst_n (S_AXI_ARESETN)
	);

	sha_axi #(
		.MSG_WORDS    (MSG_WORDS),
		.RESULT_WORDS (RESULT_WORDS)
	) sha_axi_i (.*);

	////////////////////////////////////////
	// Engine model
	always @(negedge S_AXI_ACLK) begin
		if (!hash_rst_n) begin
			hash_done = 1'b0;
			countdown = 0;
		end else if (hash_run) begin
			// Done is first sampled this many edges after the run cycle
			done_delay = 5 + ($unsigned($random(seed)) % 16);
			countdown  = done_delay;
			hash_done  = 1'b0;
		end else if (countdown > 0) begin
			countdown--;
			if (countdown == 0) begin
				hash_done = 1'b1;
			end
		end
		for (int k = 0; k < RESULT_WORDS; k++) begin
			hash_code[(RESULT_WORDS-1-k)*DATA_WIDTH +: DATA_WIDTH] =
				hash_done ? ~hash_msg[(MSG_WORDS-1-k)*DATA_WIDTH +: DATA_WIDTH] : '0;
		end
	end

	// Engine reset cycles after the bus reset
	always @(negedge S_AXI_ACLK) begin
		if (S_AXI_ARESETN && !hash_rst_n) begin
			rst_low_cycles++;
		end
	end

	// A timeout ends the run here
	initial begin : watchdog
		wait (aborted);
		print_counts();
		$display("Something failed");
		$finish;
	end

	function automatic logic flag_value(input flag_e sel);
		case (sel)
			FLAG_RESET_DONE: return S_AXI_ARESETN;
			FLAG_AWREADY:    return S_AXI_AWREADY;
			FLAG_BVALID:     return S_AXI_BVALID;
			FLAG_ARREADY:    return S_AXI_ARREADY;
			default:         return S_AXI_RVALID;
		endcase
	endfunction

	// Expected word after a strobed write
	function automatic logic [DATA_WIDTH-1:0] apply_strobes(
		input logic [DATA_WIDTH-1:0] old_word,
		input logic [DATA_WIDTH-1:0] new_word,
		input logic [3:0]            strb
	);
		logic [DATA_WIDTH-1:0] mask;
		mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
		return (old_word & ~mask) | (new_word & mask);
	endfunction

	task automatic print_counts();
		$display("Errors: %0d read mismatches, %0d assertion failures",
			errors, sha_axi_i.props_i.fail_count);
	endtask

	task automatic abort_run(input string why);
		$display("Run stopped: %s", why);
		aborted = 1'b1;
		// Parked until the watchdog ends the run
		forever @(negedge S_AXI_ACLK);
	endtask

	task automatic wait_flag(input flag_e sel, input string what);
		int t;
		t = 0;
		do begin
			@(negedge S_AXI_ACLK);
			t++;
		end while (!flag_value(sel) && t < WAIT_LIMIT);
		if (!flag_value(sel)) begin
			abort_run({"timeout waiting for ", what});
		end
	endtask

	task automatic check_word(input string name, input logic [DATA_WIDTH-1:0] got,
			input logic [DATA_WIDTH-1:0] exp);
		if (got !== exp) begin
			$display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
			errors++;
		end
	endtask

	task automatic start_write(input int idx, input logic [DATA_WIDTH-1:0] data,
			input logic [3:0] strb);
		S_AXI_AWADDR  = ADDR_WIDTH'(idx << ADDR_LSB);
		S_AXI_WDATA   = data;
		S_AXI_WSTRB   = strb;
		S_AXI_AWVALID = 1'b1;
		S_AXI_WVALID  = 1'b1;
		slot_exp[idx] = apply_strobes(slot_exp[idx], data, strb);
	endtask

	task automatic bus_write(input int idx, input logic [DATA_WIDTH-1:0] data,
			input logic [3:0] strb);
		@(negedge S_AXI_ACLK);
		start_write(idx, data, strb);
		wait_flag(FLAG_AWREADY, "write address ready");
		S_AXI_AWVALID = 1'b0;
		S_AXI_WVALID  = 1'b0;
		wait_flag(FLAG_BVALID, "write response");
		check_word("S_AXI_BRESP", S_AXI_BRESP, '0);
	endtask

	task automatic start_read(input int idx);
		S_AXI_ARADDR  = ADDR_WIDTH'(idx << ADDR_LSB);
		S_AXI_ARVALID = 1'b1;
	endtask

	task automatic bus_read(input int idx, output logic [DATA_WIDTH-1:0] data);
		@(negedge S_AXI_ACLK);
		start_read(idx);
		wait_flag(FLAG_ARREADY, "read address ready");
		S_AXI_ARVALID = 1'b0;
		wait_flag(FLAG_RVALID, "read data");
		data = S_AXI_RDATA;
		check_word("S_AXI_RRESP", S_AXI_RRESP, '0);
	endtask

	task automatic read_expect(input int idx, input logic [DATA_WIDTH-1:0] exp);
		logic [DATA_WIDTH-1:0] got;
		bus_read(idx, got);
		check_word($sformatf("S_AXI_RDATA slot %0d", idx), got, exp);
	endtask

	initial begin : stimulus
		logic [DATA_WIDTH-1:0] word;
		logic [3:0]            strb;
		int                    polls;
		for (int i = 0; i < SLOTS; i++) begin
			slot_exp[i] = '0;
		end
		wait_flag(FLAG_RESET_DONE, "reset release");

		////////////////////////////////////////
		// Length and message words, full then partial strobes
		for (int i = int'(REG_LEN0); i < int'(REG_MSG_LAST); i++) begin
			bus_write(i, $random(seed), 4'hf);
		end
		for (int i = int'(REG_LEN0); i < int'(REG_MSG_LAST); i++) begin
			strb = 4'($random(seed));
			if (strb == 4'hf) begin
				strb = 4'h5;
			end
			bus_write(i, $random(seed), strb);
		end
		for (int i = int'(REG_LEN0); i < int'(REG_MSG_LAST); i++) begin
			read_expect(i, slot_exp[i]);
		end

		// Engine side ports, first word on top
		for (int i = 0; i < LEN_WORDS; i++) begin
			check_word($sformatf("hash_len word %0d", i),
				hash_len[(LEN_WORDS-1-i)*DATA_WIDTH +: DATA_WIDTH],
				slot_exp[int'(REG_LEN0) + i]);
		end
		for (int i = 0; i < MSG_WORDS; i++) begin
			check_word($sformatf("hash_msg word %0d", i),
				hash_msg[(MSG_WORDS-1-i)*DATA_WIDTH +: DATA_WIDTH],
				slot_exp[int'(REG_MSG0) + i]);
		end

		////////////////////////////////////////
		// Back-pressure on the write response
		S_AXI_BREADY = 1'b0;
		@(negedge S_AXI_ACLK);
		start_write(int'(REG_LEN0), $random(seed), 4'hf);
		wait_flag(FLAG_AWREADY, "first held write");
		// Handshake edge passes before the next write is presented
		@(negedge S_AXI_ACLK);
		// Second write queued behind the held response
		start_write(int'(REG_LEN0) + 1, $random(seed), 4'hf);
		repeat (6) @(negedge S_AXI_ACLK);
		S_AXI_BREADY = 1'b1;
		wait_flag(FLAG_AWREADY, "second held write");
		S_AXI_AWVALID = 1'b0;
		S_AXI_WVALID  = 1'b0;
		wait_flag(FLAG_BVALID, "second write response");

		// Same on the read side
		S_AXI_RREADY = 1'b0;
		@(negedge S_AXI_ACLK);
		start_read(int'(REG_LEN0));
		wait_flag(FLAG_ARREADY, "first held read");
		@(negedge S_AXI_ACLK);
		start_read(int'(REG_LEN0) + 1);
		wait_flag(FLAG_RVALID, "first held read data");
		repeat (6) @(negedge S_AXI_ACLK);
		check_word("S_AXI_RDATA held", S_AXI_RDATA, slot_exp[int'(REG_LEN0)]);
		S_AXI_RREADY = 1'b1;
		wait_flag(FLAG_ARREADY, "second held read");
		S_AXI_ARVALID = 1'b0;
		wait_flag(FLAG_RVALID, "second held read data");
		check_word("S_AXI_RDATA second", S_AXI_RDATA, slot_exp[int'(REG_LEN0) + 1]);

		////////////////////////////////////////
		// Start, poll for done, then results and counter
		bus_write(int'(REG_MSG_LAST), $random(seed), 4'hf);
		polls = 0;
		do begin
			bus_read(int'(REG_CTRL), word);
			polls++;
		end while (!word[DATA_WIDTH-2] && polls < POLL_LIMIT);
		if (!word[DATA_WIDTH-2]) begin
			abort_run("hash_done never showed in the status word");
		end
		check_word("S_AXI_RDATA status", word, 32'h4000_0000);
		read_expect(int'(REG_CYCLES), DATA_WIDTH'(done_delay));
		for (int k = 0; k < RESULT_WORDS; k++) begin
			read_expect(int'(REG_RESULT0) + k, ~slot_exp[int'(REG_MSG0) + k]);
		end

		////////////////////////////////////////
		// Soft clear
		bus_write(int'(REG_CLEAR), '0, 4'hf);
		for (int i = 0; i <= int'(REG_CYCLES); i++) begin
			read_expect(i, '0);
		end
		check_word("hash_rst_n low cycles", rst_low_cycles, 1);
		check_word("hash_mode cleared", hash_mode, 1'b0);

		// Clear slot, unmapped slot and mode bit
		read_expect(int'(REG_CLEAR), '1);
		read_expect(UNMAPPED, '0);
		bus_write(int'(REG_CTRL), 32'h1, 4'h1);
		read_expect(int'(REG_CTRL), 32'h1);
		check_word("hash_mode", hash_mode, 1'b1);

		print_counts();
		if (errors == 0 && sha_axi_i.props_i.fail_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- sha_axi.f
sha_axi_pkg.sv
axil_slave_port.sv
sha_reg_block.sv
sha_run_ctrl.sv
sha_axi.sv
tb_clock.sv
sha_axi_properties.sv
tb_sha_axi.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_sha_axi -f sha_axi.f -o sim_sha_axi \
	|| { echo "Verilator build failed"; exit 1; }
./obj_dir/sim_sha_axi +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "Something failed" sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q "Everything OK" sim.log || { echo "Simulation ended without a verdict"; exit 1; }
echo "Simulation passed"
